// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Datapath widths of the core
  localparam int pc_w      = 12;
  localparam int sp_w      = 8;
  localparam int instr_w   = 12;
  localparam int nib_w     = 4;                  // One data word is a nibble
  localparam int mem_depth = 16;
  localparam int addr_w    = $clog2(mem_depth);

  // Memory operations are recognised by their upper eight bits
  localparam logic [7:0] op_inc_mn = 8'hF6;       // INC Mn
  localparam logic [7:0] op_dec_mn = 8'hF7;       // DEC Mn

  // Register operations use the whole word
  localparam logic [instr_w-1:0] op_inc_sp = 12'hFDB;
  localparam logic [instr_w-1:0] op_dec_sp = 12'hFCB;
  localparam logic [instr_w-1:0] op_nop    = 12'hFFB;

  // Operation kind after decode
  typedef enum logic [2:0] {
    nop,
    inc_mn,
    dec_mn,
    inc_sp,
    dec_sp,
    illegal
  } op_kind_t;

  // Memory form of the word, prefix followed by the nibble address
  typedef struct packed {
    logic [7:0]        prefix;
    logic [addr_w-1:0] addr;
  } mem_form_t;

  // The same instruction word seen either as a memory op or as a full opcode
  typedef union packed {
    mem_form_t            mem_form;
    logic [instr_w-1:0]   reg_form;
  } instr_t;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // Fetch to decode, the raw word tagged with its PC
  typedef struct packed {
    isa_pkg::instr_t                 instr;
    logic [isa_pkg::pc_w-1:0]        pc;
  } fetch_out_t;

  // Decode to execute
  typedef struct packed {
    logic [isa_pkg::pc_w-1:0]        pc;
    isa_pkg::op_kind_t               op;
    logic [isa_pkg::addr_w-1:0]      addr;   // Zero for non-memory ops
  } decode_out_t;

  // One record per completed instruction, state as it stands afterwards
  typedef struct packed {
    logic [isa_pkg::pc_w-1:0]        pc;
    isa_pkg::op_kind_t               op;
    logic [isa_pkg::addr_w-1:0]      addr;
    logic [isa_pkg::nib_w-1:0]       wr_data;  // Zero when nothing was written
    logic [isa_pkg::sp_w-1:0]        sp;
    logic                            carry;
    logic                            zero;
    logic                            illegal_flag;
  } retire_t;

endpackage

`default_nettype wire

// File: src/core/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire logic                 clk,
  input  wire logic                 reset,

  // Instruction words from the program source
  input  wire logic                 in_valid,
  output logic                      in_ready,
  input  wire isa_pkg::instr_t      in_instr,

  // Tagged words towards decode
  output logic                      out_valid,
  input  wire logic                 out_ready,
  output pipe_pkg::fetch_out_t      out
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [pc_w-1:0] pc;   // Address of the next word to be accepted
  logic            in_fire;

  // The output register can take a new word when empty or when it drains now
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      pc        <= '0;
    end else begin
      if (in_fire) begin
        out_valid <= 1'b1;
        pc        <= pc + 1'b1;   // Wraps at 12 bits
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Payload only moves on an accepted word
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out.instr <= in_instr;
      out.pc    <= pc;
    end
  end

endmodule

`default_nettype wire

// File: src/core/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire logic                   clk,
  input  wire logic                   reset,

  input  wire logic                   in_valid,
  output logic                        in_ready,
  input  wire pipe_pkg::fetch_out_t   in,

  output logic                        out_valid,
  input  wire logic                   out_ready,
  output pipe_pkg::decode_out_t       out
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic              in_fire;
  op_kind_t          dec_op;
  logic [addr_w-1:0] dec_addr;

  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  // Memory ops match on the prefix, the rest need the whole word
  always_comb begin
    dec_op   = illegal;
    dec_addr = '0;
    if (in.instr.mem_form.prefix == op_inc_mn) begin
      dec_op   = inc_mn;
      dec_addr = in.instr.mem_form.addr;
    end else if (in.instr.mem_form.prefix == op_dec_mn) begin
      dec_op   = dec_mn;
      dec_addr = in.instr.mem_form.addr;
    end else begin
      case (in.instr.reg_form)
        op_inc_sp: dec_op = inc_sp;
        op_dec_sp: dec_op = dec_sp;
        op_nop:    dec_op = nop;
        default:   dec_op = illegal;   // Anything else retires flagged
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out.pc   <= in.pc;
      out.op   <= dec_op;
      out.addr <= dec_addr;
    end
  end

endmodule

`default_nettype wire

// File: src/core/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire logic                          clk,
  input  wire logic                          reset,

  input  wire logic                          in_valid,
  output logic                               in_ready,
  input  wire pipe_pkg::decode_out_t         in,

  // Retire records
  output logic                               out_valid,
  input  wire logic                          out_ready,
  output pipe_pkg::retire_t                  out,

  // Host preload of data memory
  input  wire logic                          host_wr_en,
  input  wire logic [isa_pkg::addr_w-1:0]    host_wr_addr,
  input  wire logic [isa_pkg::nib_w-1:0]     host_wr_data
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [nib_w-1:0] mem [mem_depth];   // Data memory, contents survive reset

  logic [sp_w-1:0]  sp;
  logic             carry;
  logic             zero;

  logic             in_fire;
  logic [nib_w-1:0] rd_nibble;
  logic [nib_w-1:0] nx_nibble;
  logic [sp_w-1:0]  nx_sp;
  logic             nx_carry;
  logic             nx_zero;
  logic             mem_wr;

  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  // Read, modify and write back happen in the same cycle, so a following op
  // on the same nibble always sees the fresh value
  assign rd_nibble = mem[in.addr];

  always_comb begin
    nx_nibble = rd_nibble;
    nx_sp     = sp;
    nx_carry  = carry;
    nx_zero   = zero;
    mem_wr    = 1'b0;
    case (in.op)
      inc_mn: begin
        {nx_carry, nx_nibble} = {1'b0, rd_nibble} + 5'd1;   // Carry out of bit 3
        nx_zero               = (nx_nibble == '0);
        mem_wr                = 1'b1;
      end
      dec_mn: begin
        // Bit 4 of the difference is the borrow
        {nx_carry, nx_nibble} = {1'b0, rd_nibble} - 5'd1;
        nx_zero               = (nx_nibble == '0);
        mem_wr                = 1'b1;
      end
      inc_sp:  nx_sp = sp + 1'b1;
      dec_sp:  nx_sp = sp - 1'b1;   // 00 goes to FF
      default: ;                    // NOP and illegal leave the state alone
    endcase
  end

  // Host writes only arrive while the pipeline is idle
  always_ff @(posedge clk) begin
    if (host_wr_en) begin
      mem[host_wr_addr] <= host_wr_data;
    end
    if (in_fire && mem_wr) begin
      mem[in.addr] <= nx_nibble;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sp        <= '0;
      carry     <= 1'b0;
      zero      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        sp        <= nx_sp;
        carry     <= nx_carry;
        zero      <= nx_zero;
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Record of the state just after the instruction
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out.pc           <= in.pc;
      out.op           <= in.op;
      out.addr         <= in.addr;
      out.wr_data      <= mem_wr ? nx_nibble : '0;
      out.sp           <= nx_sp;
      out.carry        <= nx_carry;
      out.zero         <= nx_zero;
      out.illegal_flag <= (in.op == illegal);
    end
  end

endmodule

`default_nettype wire

// File: src/nibble_core.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_core (
  input  wire logic                          clk,
  input  wire logic                          reset,

  // Instruction stream in place of the program ROM
  input  wire logic                          instr_valid,
  output logic                               instr_ready,
  input  wire isa_pkg::instr_t               instr,

  // Retire stream
  output logic                               retire_valid,
  input  wire logic                          retire_ready,
  output pipe_pkg::retire_t                  retire,

  input  wire logic                          host_wr_en,
  input  wire logic [isa_pkg::addr_w-1:0]    host_wr_addr,
  input  wire logic [isa_pkg::nib_w-1:0]     host_wr_data
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic        fetch_valid;
  logic        fetch_ready;
  fetch_out_t  fetch_q;

  logic        dec_valid;
  logic        dec_ready;
  decode_out_t dec_q;

  fetch_stage fetch0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (instr_valid),
    .in_ready  (instr_ready),
    .in_instr  (instr),
    .out_valid (fetch_valid),
    .out_ready (fetch_ready),
    .out       (fetch_q)
  );

  decode_stage decode0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (fetch_valid),
    .in_ready  (fetch_ready),
    .in        (fetch_q),
    .out_valid (dec_valid),
    .out_ready (dec_ready),
    .out       (dec_q)
  );

  execute_stage execute0 (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (dec_valid),
    .in_ready     (dec_ready),
    .in           (dec_q),
    .out_valid    (retire_valid),
    .out_ready    (retire_ready),
    .out          (retire),
    .host_wr_en   (host_wr_en),
    .host_wr_addr (host_wr_addr),
    .host_wr_data (host_wr_data)
  );

endmodule

`default_nettype wire

// File: sim/tb_nibble_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nibble_core;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int max_cycles = 2000;   // All tests together take a few hundred cycles

  logic              clk = 1'b0;
  logic              reset;
  logic              instr_valid;
  logic              instr_ready;
  instr_t            instr;
  logic              retire_valid;
  logic              retire_ready;
  retire_t           retire;
  logic              host_wr_en;
  logic [addr_w-1:0] host_wr_addr;
  logic [nib_w-1:0]  host_wr_data;

  // Reference model of the architectural state
  logic [nib_w-1:0]  m_mem [mem_depth];
  logic [sp_w-1:0]   m_sp;
  logic              m_carry;
  logic              m_zero;
  logic [pc_w-1:0]   m_pc;

  retire_t exp_q[$];                  // Records still to come, oldest first
  retire_t want;
  integer  seed         = 32'h252ff088;
  int      errors       = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;
  int      cycles       = 0;
  logic    toggle_ready = 1'b0;
  logic    hold_ready   = 1'b0;       // Keeps retire_ready low so records pile up
  logic [31:0] ready_rnd;

  nibble_core dut0 (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire),
    .host_wr_en   (host_wr_en),
    .host_wr_addr (host_wr_addr),
    .host_wr_data (host_wr_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("The run hit the limit of %0d cycles and was stopped", max_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Back-pressure on the retire stream
  always @(posedge clk) begin
    #1;
    if (hold_ready) begin
      retire_ready = 1'b0;
    end else if (toggle_ready) begin
      ready_rnd    = $random(seed);
      retire_ready = ready_rnd[0];
    end else begin
      retire_ready = 1'b1;
    end
  end

  // One record as text for error lines
  function automatic string record_text(input retire_t r);
    return $sformatf("pc %0d op %0d addr %0h data %0h sp %0h c %b z %b ill %b",
                     r.pc, r.op, r.addr, r.wr_data, r.sp, r.carry, r.zero, r.illegal_flag);
  endfunction

  // Handshake signals are stable at the falling edge, the transfer follows at the rising one
  always @(negedge clk) begin
    if (retire_valid === 1'b1 && retire_ready === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("A retire record for PC %0d arrived with none outstanding", retire.pc);
      end else begin
        want = exp_q.pop_front();
        if (retire !== want) begin
          errors++;
          $display("Error at time %0t: got %s, expected %s", $time, record_text(retire),
                   record_text(want));
        end
      end
    end
  end

  function automatic op_kind_t model_decode(input logic [instr_w-1:0] w);
    if (w[11:4] == op_inc_mn) return inc_mn;
    if (w[11:4] == op_dec_mn) return dec_mn;
    if (w == op_inc_sp) return inc_sp;
    if (w == op_dec_sp) return dec_sp;
    if (w == op_nop) return nop;
    return illegal;
  endfunction

  // Called 1 ns after a rising edge; returns 1 ns after the edge that took the word
  task automatic send_instr(input logic [instr_w-1:0] word);
    retire_t           r;
    op_kind_t          k;
    logic [addr_w-1:0] a;
    begin
      k    = model_decode(word);
      a    = word[addr_w-1:0];
      r    = '0;
      r.pc = m_pc;
      r.op = k;
      case (k)
        inc_mn: begin
          m_carry  = (m_mem[a] == 4'hF);   // Wrap to zero
          m_mem[a] = m_mem[a] + 1'b1;
          m_zero   = (m_mem[a] == 4'h0);
          r.addr    = a;
          r.wr_data = m_mem[a];
        end
        dec_mn: begin
          m_carry  = (m_mem[a] == 4'h0);   // Borrow below zero
          m_mem[a] = m_mem[a] - 1'b1;
          m_zero   = (m_mem[a] == 4'h0);
          r.addr    = a;
          r.wr_data = m_mem[a];
        end
        inc_sp:  m_sp = m_sp + 1'b1;
        dec_sp:  m_sp = m_sp - 1'b1;
        illegal: r.illegal_flag = 1'b1;
        default: ;
      endcase
      r.sp    = m_sp;
      r.carry = m_carry;
      r.zero  = m_zero;
      m_pc    = m_pc + 1'b1;
      exp_q.push_back(r);
      instr_valid    = 1'b1;
      instr.reg_form = word;
      @(negedge clk);
      while (instr_ready !== 1'b1) @(negedge clk);
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
    end
  endtask

  task automatic host_write(input logic [addr_w-1:0] a, input logic [nib_w-1:0] d);
    host_wr_en   = 1'b1;
    host_wr_addr = a;
    host_wr_data = d;
    @(posedge clk);
    #1;
    host_wr_en = 1'b0;
    m_mem[a]   = d;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset   = 1'b0;
    m_pc    = '0;
    m_sp    = '0;
    m_carry = 1'b0;
    m_zero  = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic test_inc_mem();
    int e;
    e = errors;
    for (int i = 0; i < mem_depth; i++) host_write(4'(i), 4'(i + 2));   // Address 13 holds F
    for (int i = 0; i < mem_depth; i++) send_instr({op_inc_mn, 4'(i)});
    wait_idle();
    report_test("inc_mem", e);
  endtask

  task automatic test_dec_mem();
    int e;
    e = errors;
    for (int i = 0; i < mem_depth; i++) host_write(4'(i), 4'(i));
    for (int i = 0; i < mem_depth; i++) send_instr({op_dec_mn, 4'(i)});
    wait_idle();
    report_test("dec_mem", e);
  endtask

  task automatic test_sp();
    int e;
    e = errors;
    host_write(0, 4'hF);
    send_instr({op_inc_mn, 4'h0});   // Leaves carry and zero set
    send_instr(op_dec_sp);           // 00 wraps to FF
    send_instr(op_dec_sp);
    repeat (3) send_instr(op_inc_sp);
    send_instr(op_dec_sp);
    wait_idle();
    report_test("stack_pointer", e);
  endtask

  task automatic test_nop_illegal();
    int          e;
    logic [31:0] rnd;
    e = errors;
    send_instr(op_nop);
    send_instr(12'h000);
    send_instr(12'hFDA);
    send_instr(12'hF5F);
    send_instr(op_nop);
    repeat (8) begin
      rnd = $random(seed);
      while (model_decode(rnd[11:0]) != illegal) rnd = $random(seed);
      send_instr(rnd[11:0]);
    end
    wait_idle();
    report_test("nop_illegal", e);
  endtask

  task automatic test_stream();
    int          e;
    logic [31:0] rnd;
    e = errors;
    host_write(5, 4'hE);
    toggle_ready = 1'b1;
    repeat (24) begin
      rnd = $random(seed);
      send_instr(rnd[0] ? {op_inc_mn, 4'h5} : {op_dec_mn, 4'h5});
    end
    wait_idle();
    toggle_ready = 1'b0;
    report_test("stream_backpressure", e);
  endtask

  task automatic test_reset();
    int e;
    e = errors;
    host_write(0, 4'hF);
    send_instr({op_inc_mn, 4'h0});   // Carry and zero set before the reset
    wait_idle();
    hold_ready = 1'b1;
    repeat (3) send_instr(op_inc_sp);   // Only the first reaches execute and moves SP
    apply_reset();
    exp_q.delete();                     // Records caught in the pipeline are dropped
    hold_ready = 1'b0;
    if (retire_valid !== 1'b0 || instr_ready !== 1'b1) begin
      errors++;
      $display("Error at time %0t: pipeline not empty after reset", $time);
    end
    send_instr(op_nop);
    wait_idle();
    apply_reset();
    send_instr(op_inc_sp);
    wait_idle();
    report_test("reset_state", e);
  endtask

  initial begin
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b1;
    host_wr_en   = 1'b0;
    host_wr_addr = '0;
    host_wr_data = '0;
    apply_reset();
    test_inc_mem();
    test_dec_mem();
    test_sp();
    test_nop_illegal();
    test_stream();
    test_reset();
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: nibble_core.f
common/isa_pkg.sv
common/pipe_pkg.sv
src/core/fetch_stage.sv
src/core/decode_stage.sv
src/core/execute_stage.sv
src/nibble_core.sv
sim/tb_nibble_core.sv

// File: Bender.yml
package:
  name: nibble_core

sources:
  # Packages first, then the stages and the top level
  - common/isa_pkg.sv
  - common/pipe_pkg.sv
  - src/core/fetch_stage.sv
  - src/core/decode_stage.sv
  - src/core/execute_stage.sv
  - src/nibble_core.sv

  - target: simulation
    files:
      - sim/tb_nibble_core.sv
